// File: Bender.yml
package:
  name: bk_backup_ram

sources:
  - bk_pkg.sv
  - bk_apb_regs.sv
  - bk_sector_counter.sv
  - bk_sequencer.sv
  - backup_ram.sv
  - bk_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_bk_top.sv

// File: backup_ram.sv
/*
 * Backup save memory, 2048 x 8 true dual port
 * Console byte port and SD sector buffer port, both with registered reads
 */
`timescale 1ns/1ps
`default_nettype none

module backup_ram (
	input  wire                    clk_sys,
	input  wire bk_pkg::brm_port_t brm,
	output bk_pkg::byte_t          brm_rdata,
	input  wire bk_pkg::sect_idx_t sector,
	input  wire bk_pkg::sd_buf_t   sd_buf,
	output bk_pkg::byte_t          sd_buf_rdata
);

	bk_pkg::byte_t     mem [0:(1 << bk_pkg::BRM_AW) - 1];
	bk_pkg::brm_addr_t sd_addr;
	logic              sd_we;

	// Sector selects the 512-byte window
	assign sd_addr = {sector, sd_buf.addr};
	assign sd_we   = sd_buf.wr & sd_buf.ack;

	// Console port
	always @(posedge clk_sys) begin
		if (brm.we)
			mem[brm.addr] <= brm.wdata;
		brm_rdata <= mem[brm.addr];
	end

	// SD buffer port
	always @(posedge clk_sys) begin
		if (sd_we)
			mem[sd_addr] <= sd_buf.wdata;
		sd_buf_rdata <= mem[sd_addr];  // Save data, one cycle behind addr
	end

endmodule

`default_nettype wire

// File: bk_apb_regs.sv
/*
 * APB register block for the backup RAM
 * Enable flag, control word decode into load/save pulses, status readback
 */
`timescale 1ns/1ps
`default_nettype none

module bk_apb_regs (
	input  wire                clk_sys,
	input  wire                rst_n,
	input  wire bk_pkg::apb_req_t apb,
	output bk_pkg::apb_data_t  prdata,
	input  wire                busy,
	input  wire                loading,
	output logic               start_load,
	output logic               start_save
);

	logic              enable;
	logic              ena_next;
	logic              wr_ctrl;
	logic              rd_status;
	logic              go_mount;
	logic              go_save;
	logic              go_cart;
	bk_pkg::apb_data_t status;

	// =====================================================================
	// Control write decode
	// =====================================================================
	// Access phase of a write, no wait states
	assign wr_ctrl = apb.psel & apb.penable & apb.pwrite &
		(apb.paddr == bk_pkg::ADDR_CTRL);

	assign go_mount = wr_ctrl & apb.pwdata[bk_pkg::CTRL_MOUNT];
	assign go_save  = wr_ctrl & apb.pwdata[bk_pkg::CTRL_SAVE];
	assign go_cart  = wr_ctrl & apb.pwdata[bk_pkg::CTRL_CART];

	// Cart download wins over a mount in the same word
	always_comb begin
		ena_next = enable;
		if (go_mount)
			ena_next = 1'b1;
		if (go_cart)
			ena_next = 1'b0;
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			enable     <= 1'b0;
			start_load <= 1'b0;
			start_save <= 1'b0;
		end else begin
			enable     <= ena_next;
			// Requests while disabled or busy are dropped
			start_load <= go_mount & ena_next & ~busy;
			start_save <= go_save & ~go_mount & ena_next & ~busy;  // Load first
		end
	end

	// =====================================================================
	// Status readback
	// =====================================================================
	always_comb begin
		status                   = '0;
		status[bk_pkg::STAT_ENA]  = enable;
		status[bk_pkg::STAT_BUSY] = busy;
		status[bk_pkg::STAT_LOAD] = loading;
	end

	assign rd_status = apb.psel & ~apb.pwrite & (apb.paddr == bk_pkg::ADDR_STATUS);

	// Valid through setup and access cycles
	assign prdata = rd_status ? status : '0;

endmodule

`default_nettype wire

// File: bk_pkg.sv
/*
 * Backup RAM package
 * Widths, APB register map, vector types, sequencer states and bus structs
 */
`default_nettype none

package bk_pkg;

	// =====================================================================
	// Sizes and register map
	// =====================================================================
	localparam int BRM_AW       = 11;  // 2 KiB save memory
	localparam int SECT_AW      = 9;   // 512 bytes per SD sector
	localparam int SECT_IDX_W   = 2;
	localparam int LBA_W        = 32;
	localparam int SECTOR_COUNT = 4;

	localparam logic [3:0] ADDR_CTRL   = 4'h0;
	localparam logic [3:0] ADDR_STATUS = 4'h4;

	localparam int CTRL_MOUNT = 0;  // Image mounted, enables backup and loads
	localparam int CTRL_SAVE  = 1;
	localparam int CTRL_CART  = 2;  // Cartridge download, disables backup

	localparam int STAT_ENA  = 0;
	localparam int STAT_BUSY = 1;
	localparam int STAT_LOAD = 2;

	// =====================================================================
	// Types
	// =====================================================================
	typedef logic [BRM_AW-1:0]     brm_addr_t;
	typedef logic [7:0]            byte_t;
	typedef logic [SECT_AW-1:0]    sect_addr_t;
	typedef logic [SECT_IDX_W-1:0] sect_idx_t;
	typedef logic [LBA_W-1:0]      lba_t;
	typedef logic [3:0]            apb_addr_t;
	typedef logic [31:0]           apb_data_t;

	typedef enum logic [1:0] {IDLE, REQUEST, WAIT_END} bk_state_e;

	typedef struct packed {
		logic      psel;
		logic      penable;
		logic      pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
	} apb_req_t;

	typedef struct packed {
		brm_addr_t addr;
		byte_t     wdata;
		logic      we;
	} brm_port_t;

	typedef struct packed {
		lba_t lba;
		logic rd;
		logic wr;
	} sd_req_t;

	typedef struct packed {
		sect_addr_t addr;
		byte_t      wdata;
		logic       wr;    // Host data strobe
		logic       ack;
	} sd_buf_t;

endpackage

`default_nettype wire

// File: bk_sector_counter.sv
/*
 * Save sector counter
 * Clear at transfer start, advance per completed sector, last-sector flag
 */
`timescale 1ns/1ps
`default_nettype none

module bk_sector_counter (
	input  wire               clk_sys,
	input  wire               rst_n,
	input  wire               clear,
	input  wire               advance,
	output bk_pkg::sect_idx_t sector,
	output logic              last
);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			sector <= '0;
		end else if (clear) begin
			sector <= '0;
		end else if (advance) begin
			sector <= sector + bk_pkg::sect_idx_t'(1);
		end
	end

	// Final sector of the image
	assign last = (sector == bk_pkg::sect_idx_t'(bk_pkg::SECTOR_COUNT - 1));

endmodule

`default_nettype wire

// File: bk_sequencer.sv
/*
 * Backup transfer sequencer
 * Runs load/save over the SD block request handshake, one sector at a time,
 * and pulses the console reset after a finished load
 */
`timescale 1ns/1ps
`default_nettype none

module bk_sequencer (
	input  wire               clk_sys,
	input  wire               rst_n,
	input  wire               start_load,
	input  wire               start_save,
	input  wire               ack,
	input  wire               last,
	output logic              clear,
	output logic              advance,
	output bk_pkg::sd_req_t   sd_req,
	input  wire bk_pkg::sect_idx_t sector,
	output logic              busy,
	output logic              loading,
	output logic              bk_reset
);

	bk_pkg::bk_state_e state;
	logic              ack_d;
	logic              ack_rise;
	logic              ack_fall;
	logic              start;
	logic              rd_q;
	logic              wr_q;

	assign start    = start_load | start_save;
	assign ack_rise = ack & ~ack_d;
	assign ack_fall = ~ack & ack_d;  // Host finished the sector

	// Counter steering
	assign clear   = (state == bk_pkg::IDLE) & start;
	assign advance = (state == bk_pkg::WAIT_END) & ack_fall & ~last;

	assign busy = (state != bk_pkg::IDLE);

	// Sector index doubles as the block address
	assign sd_req = '{lba: bk_pkg::lba_t'(sector), rd: rd_q, wr: wr_q};

	// =====================================================================
	// Transfer FSM
	// =====================================================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state    <= bk_pkg::IDLE;
			ack_d    <= 1'b0;
			rd_q     <= 1'b0;
			wr_q     <= 1'b0;
			loading  <= 1'b0;
			bk_reset <= 1'b0;
		end else begin
			ack_d    <= ack;
			bk_reset <= 1'b0;

			case (state)
				bk_pkg::IDLE: begin
					if (start) begin
						loading <= start_load;
						rd_q    <= start_load;
						wr_q    <= ~start_load;
						state   <= bk_pkg::REQUEST;
					end
				end

				bk_pkg::REQUEST: begin
					// Host took the request
					if (ack_rise) begin
						rd_q  <= 1'b0;
						wr_q  <= 1'b0;
						state <= bk_pkg::WAIT_END;
					end
				end

				bk_pkg::WAIT_END: begin
					if (ack_fall) begin
						if (last) begin
							bk_reset <= loading;  // Restart console on fresh save data
							loading  <= 1'b0;
							state    <= bk_pkg::IDLE;
						end else begin
							rd_q  <= loading;
							wr_q  <= ~loading;
							state <= bk_pkg::REQUEST;
						end
					end
				end

				default: state <= bk_pkg::IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: bk_top.sv
/*
 * Backup RAM subsystem top level
 * APB registers, transfer sequencer, sector counter and save memory
 */
`timescale 1ns/1ps
`default_nettype none

module bk_top (
	input  wire                    clk_sys,
	input  wire                    rst_n,
	input  wire bk_pkg::apb_req_t  apb,
	output bk_pkg::apb_data_t      prdata,
	input  wire bk_pkg::brm_port_t brm,
	output bk_pkg::byte_t          brm_rdata,
	output bk_pkg::sd_req_t        sd_req,
	input  wire bk_pkg::sd_buf_t   sd_buf,
	output bk_pkg::byte_t          sd_buf_rdata,
	output logic                   bk_reset
);

	logic              start_load;
	logic              start_save;
	logic              busy;
	logic              loading;
	logic              clear;
	logic              advance;
	logic              last;
	bk_pkg::sect_idx_t sector;

	bk_apb_regs i_regs (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.apb        (apb),
		.prdata     (prdata),
		.busy       (busy),
		.loading    (loading),
		.start_load (start_load),
		.start_save (start_save)
	);

	bk_sequencer i_seq (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.start_load (start_load),
		.start_save (start_save),
		.ack        (sd_buf.ack),
		.last       (last),
		.clear      (clear),
		.advance    (advance),
		.sd_req     (sd_req),
		.sector     (sector),
		.busy       (busy),
		.loading    (loading),
		.bk_reset   (bk_reset)
	);

	bk_sector_counter i_sect (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.clear   (clear),
		.advance (advance),
		.sector  (sector),
		.last    (last)
	);

	backup_ram i_ram (
		.clk_sys      (clk_sys),
		.brm          (brm),
		.brm_rdata    (brm_rdata),
		.sector       (sector),
		.sd_buf       (sd_buf),
		.sd_buf_rdata (sd_buf_rdata)
	);

endmodule

`default_nettype wire

// File: tb.f
bk_pkg.sv
bk_apb_regs.sv
bk_sector_counter.sv
bk_sequencer.sv
backup_ram.sv
bk_top.sv
tb_clk_gen.sv
tb_bk_top.sv

// File: tb_bk_top.sv
/*
 * Directed testbench for the backup RAM subsystem
 * SD host model, APB and console port tasks, compare tasks and timeout
 */
`timescale 1ns/1ps
`default_nettype none

module tb_bk_top;

	// Four transfers of four ~530-cycle sectors plus ~6500 cycles of console traffic
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int MEM_SIZE       = 1 << bk_pkg::BRM_AW;

	logic                  clk_sys;
	logic                  rst_n;
	bk_pkg::apb_req_t      apb;
	bk_pkg::apb_data_t     prdata;
	bk_pkg::brm_port_t     brm;
	bk_pkg::byte_t         brm_rdata;
	bk_pkg::sd_req_t       sd_req;
	bk_pkg::sd_buf_t       sd_buf;
	bk_pkg::byte_t         sd_buf_rdata;
	logic                  bk_reset;

	integer                seed = 32'hbadf;
	int                    cycle_count = 0;
	int                    reset_pulses = 0;
	bk_pkg::lba_t          req_lba[$];   // Requests seen by the host
	logic                  req_load[$];
	bk_pkg::byte_t         saved [0:MEM_SIZE-1];
	bk_pkg::byte_t         image [0:MEM_SIZE-1];

	tb_clk_gen i_clk_gen (.clk_sys(clk_sys), .rst_n(rst_n));

	bk_top i_dut (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.apb          (apb),
		.prdata       (prdata),
		.brm          (brm),
		.brm_rdata    (brm_rdata),
		.sd_req       (sd_req),
		.sd_buf       (sd_buf),
		.sd_buf_rdata (sd_buf_rdata),
		.bk_reset     (bk_reset)
	);

	// =====================================================================
	// Error reporting and compare tasks
	// =====================================================================
	task automatic stop_run(input string what);
		$display("%s", what);
		$display("** FAIL **");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_word(input string name, input bk_pkg::apb_data_t exp,
		input bk_pkg::apb_data_t act);
		if (act !== exp)
			stop_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_byte(input string name, input bk_pkg::byte_t exp,
		input bk_pkg::byte_t act);
		if (act !== exp)
			stop_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_lba(input string name, input bk_pkg::lba_t exp,
		input bk_pkg::lba_t act);
		if (act !== exp)
			stop_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_cond(input logic ok, input string what);
		if (ok !== 1'b1)
			stop_run($sformatf("Error: %s", what));
	endtask

	// Load image byte is lba*37 + offset
	function automatic bk_pkg::byte_t load_pattern(input bk_pkg::lba_t lba, input int off);
		return bk_pkg::byte_t'(int'(lba) * 37 + off);
	endfunction

	always @(posedge clk_sys) begin
		cycle_count = cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES)
			stop_run("Error: timeout, the DUT did not finish within the cycle limit");
	end

	always @(negedge clk_sys)
		if (bk_reset === 1'b1)
			reset_pulses = reset_pulses + 1;

	// =====================================================================
	// SD host model
	// =====================================================================
	initial begin : sd_host
		bk_pkg::lba_t lba;
		logic         is_load;
		int           delay;
		sd_buf = '0;
		forever begin
			@(negedge clk_sys);
			if (sd_req.rd === 1'b1 || sd_req.wr === 1'b1) begin
				check_cond(sd_req.rd !== sd_req.wr, "SD request drove rd and wr together");
				is_load = sd_req.rd;
				lba     = sd_req.lba;
				req_lba.push_back(lba);
				req_load.push_back(is_load);
				delay = $unsigned($random(seed)) % 16;  // Random answer latency
				repeat (delay) @(posedge clk_sys);
				for (int i = 0; i <= 512; i++) begin
					@(posedge clk_sys);
					if (i < 512)
						sd_buf <= '{addr: bk_pkg::sect_addr_t'(i), wdata: load_pattern(lba, i),
							wr: is_load, ack: 1'b1};
					else
						sd_buf <= '{addr: 9'd511, wdata: 8'h00, wr: 1'b0, ack: 1'b0};
					@(negedge clk_sys);
					if (!is_load && i > 0)
						saved[int'(lba) * 512 + i - 1] = sd_buf_rdata;  // Data of addr i-1
				end
			end
		end
	end

	// =====================================================================
	// Bus tasks
	// =====================================================================
	task automatic apb_write(input bk_pkg::apb_addr_t addr, input bk_pkg::apb_data_t data);
		@(posedge clk_sys);
		apb <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
		@(posedge clk_sys);
		apb.penable <= 1'b1;
		@(posedge clk_sys);
		apb <= '0;
	endtask

	task automatic apb_read(input bk_pkg::apb_addr_t addr, output bk_pkg::apb_data_t data);
		@(posedge clk_sys);
		apb <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
		@(posedge clk_sys);
		apb.penable <= 1'b1;
		@(negedge clk_sys);
		data = prdata;
		@(posedge clk_sys);
		apb <= '0;
	endtask

	task automatic brm_write(input bk_pkg::brm_addr_t addr, input bk_pkg::byte_t data);
		@(posedge clk_sys);
		brm <= '{addr: addr, wdata: data, we: 1'b1};
	endtask

	task automatic brm_release();
		@(posedge clk_sys);
		brm <= '0;
	endtask

	task automatic brm_read(input bk_pkg::brm_addr_t addr, output bk_pkg::byte_t data);
		@(posedge clk_sys);
		brm <= '{addr: addr, wdata: 8'h00, we: 1'b0};
		@(posedge clk_sys);
		@(negedge clk_sys);
		data = brm_rdata;
	endtask

	task automatic wait_first_request();
		while (req_lba.size() == 0)
			@(posedge clk_sys);
	endtask

	// Poll the busy bit until the transfer ends
	task automatic wait_idle();
		bk_pkg::apb_data_t st;
		st = '1;
		while (st[bk_pkg::STAT_BUSY] !== 1'b0)
			apb_read(bk_pkg::ADDR_STATUS, st);
	endtask

	task automatic check_requests(input string name, input logic is_load);
		check_cond(req_lba.size() == bk_pkg::SECTOR_COUNT,
			$sformatf("%s saw %0d sector requests instead of 4", name, req_lba.size()));
		for (int k = 0; k < bk_pkg::SECTOR_COUNT; k++) begin
			check_lba(name, bk_pkg::lba_t'(k), req_lba[k]);
			check_cond(req_load[k] === is_load,
				$sformatf("%s request had the wrong direction", name));
		end
	endtask

	// =====================================================================
	// Tests
	// =====================================================================
	task automatic test_reset_state();
		bk_pkg::apb_data_t st;
		apb_read(bk_pkg::ADDR_STATUS, st);
		check_word("reset status", 32'h0, st);
		check_cond(sd_req.rd === 1'b0 && sd_req.wr === 1'b0 && bk_reset === 1'b0,
			"SD request or console reset not low after reset");
		apb_write(bk_pkg::ADDR_CTRL, 32'h1 << bk_pkg::CTRL_SAVE);
		repeat (32) @(posedge clk_sys);
		check_cond(req_lba.size() == 0, "SAVE while disabled started a transfer");
	endtask

	task automatic test_console_port();
		bk_pkg::brm_addr_t base;
		bk_pkg::byte_t     data [0:63];
		bk_pkg::byte_t     rd;
		base = bk_pkg::brm_addr_t'($random(seed));
		for (int i = 0; i < 64; i++) begin
			data[i] = bk_pkg::byte_t'($random(seed));
			brm_write(base + bk_pkg::brm_addr_t'(i), data[i]);
		end
		brm_release();
		for (int i = 0; i < 64; i++) begin
			brm_read(base + bk_pkg::brm_addr_t'(i), rd);
			check_byte("console port", data[i], rd);
		end
	endtask

	task automatic test_load();
		bk_pkg::apb_data_t st;
		bk_pkg::byte_t     rd;
		req_lba.delete();
		req_load.delete();
		reset_pulses = 0;
		apb_write(bk_pkg::ADDR_CTRL, 32'h1 << bk_pkg::CTRL_MOUNT);
		wait_first_request();
		apb_read(bk_pkg::ADDR_STATUS, st);
		check_word("load busy status", 32'h7, st);  // Enable, busy and load
		wait_idle();
		check_requests("load", 1'b1);
		check_cond(reset_pulses == 1, "console reset did not pulse exactly once after load");
		for (int a = 0; a < MEM_SIZE; a++) begin
			brm_read(bk_pkg::brm_addr_t'(a), rd);
			check_byte("load data", load_pattern(bk_pkg::lba_t'(a >> 9), a % 512), rd);
		end
	endtask

	task automatic test_save();
		bk_pkg::apb_data_t st;
		for (int a = 0; a < MEM_SIZE; a++) begin
			image[a] = bk_pkg::byte_t'($random(seed));
			brm_write(bk_pkg::brm_addr_t'(a), image[a]);
		end
		brm_release();
		req_lba.delete();
		req_load.delete();
		reset_pulses = 0;
		apb_write(bk_pkg::ADDR_CTRL, 32'h1 << bk_pkg::CTRL_SAVE);
		wait_first_request();
		apb_read(bk_pkg::ADDR_STATUS, st);
		check_word("save busy status", 32'h3, st);  // Enable and busy without load
		wait_idle();
		check_requests("save", 1'b0);
		check_cond(reset_pulses == 0, "console reset pulsed after a save");
		for (int a = 0; a < MEM_SIZE; a++)
			check_byte("save image", image[a], saved[a]);
	endtask

	task automatic test_gating();
		bk_pkg::apb_data_t st;
		req_lba.delete();
		req_load.delete();
		apb_write(bk_pkg::ADDR_CTRL, 32'h1 << bk_pkg::CTRL_SAVE);
		wait_first_request();
		apb_write(bk_pkg::ADDR_CTRL, 32'h1 << bk_pkg::CTRL_SAVE);  // Dropped while busy
		wait_idle();
		repeat (32) @(posedge clk_sys);
		check_requests("save while busy", 1'b0);
		apb_write(bk_pkg::ADDR_CTRL, 32'h1 << bk_pkg::CTRL_CART);
		apb_read(bk_pkg::ADDR_STATUS, st);
		check_word("cart status", 32'h0, st);
		req_lba.delete();
		req_load.delete();
		apb_write(bk_pkg::ADDR_CTRL, 32'h1 << bk_pkg::CTRL_SAVE);
		repeat (32) @(posedge clk_sys);
		check_cond(req_lba.size() == 0, "SAVE after a cartridge download started a transfer");
		apb_write(bk_pkg::ADDR_CTRL, 32'h1 << bk_pkg::CTRL_MOUNT);
		wait_first_request();
		wait_idle();
		check_requests("mount after cart", 1'b1);
	endtask

	initial begin
		apb = '0;
		brm = '0;
		@(posedge rst_n);
		@(posedge clk_sys);
		test_reset_state();
		test_console_port();
		test_load();
		test_save();
		test_gating();
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
/*
 * Testbench clock and reset generator
 * 10 ns clk_sys, rst_n held low for four cycles
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
	output logic clk_sys,
	output logic rst_n
);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;  // 100 MHz
	end

	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk_sys);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire
